/* hw/des_pkg.sv */
// DES shared types, pipeline stage record and S-box lookup
// Bit numbering follows the standard with DES bit 1 at the MSB
`default_nettype none

package des_pkg;

  typedef logic [63:0] block_t;    // Plaintext or ciphertext
  typedef logic [63:0] key_t;      // Key with parity bits
  typedef logic [31:0] half_t;     // L or R
  typedef logic [27:0] kh_t;       // Key half C or D
  typedef logic [47:0] subkey_t;
  typedef logic [3:0]  sbox_out_t;

  // Record passed between pipeline stages
  typedef struct packed {
    logic  valid;
    half_t l;
    half_t r;
    kh_t   c;
    kh_t   d;
  } stage_t;

  // S-box contents with entry n at row n/16 and column n%16
  localparam logic [0:63][3:0] SBOX1 = {
    64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
    64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D
  };
  localparam logic [0:63][3:0] SBOX2 = {
    64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
    64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9
  };
  localparam logic [0:63][3:0] SBOX3 = {
    64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
    64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C
  };
  localparam logic [0:63][3:0] SBOX4 = {
    64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
    64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E
  };
  localparam logic [0:63][3:0] SBOX5 = {
    64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
    64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453
  };
  localparam logic [0:63][3:0] SBOX6 = {
    64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
    64'h9EF528C3704A1DB6, 64'h432C95FABE17608D
  };
  localparam logic [0:63][3:0] SBOX7 = {
    64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
    64'h14BDC37EAF680592, 64'h6BD814A7950FE23C
  };
  localparam logic [0:63][3:0] SBOX8 = {
    64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
    64'h7B419CE206ADF358, 64'h21E74A8DFC90356B
  };

  // Row from the outer bits, column from the inner four
  function automatic sbox_out_t sbox_lookup(input int idx, input logic [5:0] grp);
    logic [5:0] sel;
    sbox_out_t  res;
    sel = {grp[5], grp[0], grp[4:1]};
    case (idx)
      1:       res = SBOX1[sel];
      2:       res = SBOX2[sel];
      3:       res = SBOX3[sel];
      4:       res = SBOX4[sel];
      5:       res = SBOX5[sel];
      6:       res = SBOX6[sel];
      7:       res = SBOX7[sel];
      8:       res = SBOX8[sel];
      default: res = '0;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

/* hw/des_input_stage.sv */
// DES input stage
// Registers the IP-permuted block and the PC1 key halves with the valid strobe
`timescale 1ns/10ps
`default_nettype none

module des_input_stage
  import des_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   arst_n,
  input  wire logic   in_valid,
  input  wire block_t message,
  input  wire key_t   key,
  output stage_t      stage_out
);

  localparam int IP [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9,  1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
  };

  // Parity bits 8, 16, ... 64 are dropped
  localparam int PC1 [56] = '{
    57, 49, 41, 33, 25, 17, 9,  1,  58, 50, 42, 34, 26, 18,
    10, 2,  59, 51, 43, 35, 27, 19, 11, 3,  60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7,  62, 54, 46, 38, 30, 22,
    14, 6,  61, 53, 45, 37, 29, 21, 13, 5,  28, 20, 12, 4
  };

  block_t      ip_block;
  logic [55:0] pc1_key;

  always_comb
  begin
    for (int i = 0; i < 64; i++)
      ip_block[63-i] = message[64-IP[i]];
    for (int i = 0; i < 56; i++)
      pc1_key[55-i] = key[64-PC1[i]];
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      stage_out <= '0;
    else
      stage_out <= '{valid: in_valid, l: ip_block[63:32], r: ip_block[31:0],
                     c: pc1_key[55:28], d: pc1_key[27:0]};
  end

endmodule

`default_nettype wire

/* hw/des_round.sv */
// One registered DES Feistel round
// Rotates the key halves, forms the PC2 subkey and applies f(R, K)
`timescale 1ns/10ps
`default_nettype none

module des_round
  import des_pkg::*;
#(
  parameter int round_idx = 1
)(
  input  wire logic   clk,
  input  wire logic   arst_n,
  input  wire stage_t stage_in,
  output stage_t      stage_out
);

  localparam int SHIFT = (round_idx == 1 || round_idx == 2 ||
                          round_idx == 9 || round_idx == 16) ? 1 : 2;

  localparam int E [48] = '{
    32, 1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9,  10, 11,
    12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
    22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
  };

  localparam int P [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1,  15, 23, 26, 5,  18, 31, 10,
    2,  8, 24, 14, 32, 27, 3,  9,  19, 13, 30, 6,  22, 11, 4,  25
  };

  localparam int PC2 [48] = '{
    14, 17, 11, 24, 1,  5,  3,  28, 15, 6,  21, 10, 23, 19, 12, 4,
    26, 8,  16, 7,  27, 20, 13, 2,  41, 52, 31, 37, 47, 55, 30, 40,
    51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  kh_t         c_rot;
  kh_t         d_rot;
  logic [55:0] cd_rot;
  subkey_t     subkey;
  subkey_t     mixed;
  half_t       sbox_out;
  half_t       f_out;

  assign c_rot = (stage_in.c << SHIFT) | (stage_in.c >> (28 - SHIFT));
  assign d_rot = (stage_in.d << SHIFT) | (stage_in.d >> (28 - SHIFT));
  assign cd_rot = {c_rot, d_rot};

  always_comb
  begin
    for (int i = 0; i < 48; i++)
    begin
      subkey[47-i] = cd_rot[56-PC2[i]];
      mixed[47-i]  = stage_in.r[32-E[i]] ^ subkey[47-i];  // Expansion plus key mixing
    end
    for (int j = 0; j < 8; j++)
      sbox_out[31-4*j -: 4] = sbox_lookup(j + 1, mixed[47-6*j -: 6]);
    for (int i = 0; i < 32; i++)
      f_out[31-i] = sbox_out[32-P[i]];
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      stage_out <= '0;
    else
      stage_out <= '{valid: stage_in.valid, l: stage_in.r, r: stage_in.l ^ f_out,
                     c: c_rot, d: d_rot};
  end

endmodule

`default_nettype wire

/* hw/des_output_stage.sv */
// DES drain stage with the final swap and inverse initial permutation
`timescale 1ns/10ps
`default_nettype none

module des_output_stage
  import des_pkg::*;
(
  input  wire stage_t stage_in,
  output logic        out_valid,
  output block_t      ciphertext
);

  localparam int IP_INV [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9,  49, 17, 57, 25
  };

  block_t preout;

  assign preout = {stage_in.r, stage_in.l};  // R16 L16
  assign out_valid = stage_in.valid;

  always_comb
  begin
    for (int i = 0; i < 64; i++)
      ciphertext[63-i] = preout[64-IP_INV[i]];
  end

endmodule

`default_nettype wire

/* hw/des_encrypt.sv */
// Pipelined DES encryption core
// Input stage, NUM_ROUNDS registered rounds and a combinational drain stage
`timescale 1ns/10ps
`default_nettype none

module des_encrypt
  import des_pkg::*;
#(
  parameter int NUM_ROUNDS = 16
)(
  input  wire logic   clk,
  input  wire logic   arst_n,
  input  wire logic   in_valid,
  input  wire block_t message,
  input  wire key_t   key,
  output logic        out_valid,
  output block_t      ciphertext
);

  stage_t stage [0:NUM_ROUNDS];

  des_input_stage u_input_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .message   (message),
    .key       (key),
    .stage_out (stage[0])
  );

  // One block per cycle through the rounds
  for (genvar k = 1; k <= NUM_ROUNDS; k++)
  begin : g_round
    des_round #(
      .round_idx (k)
    ) u_round (
      .clk       (clk),
      .arst_n    (arst_n),
      .stage_in  (stage[k-1]),
      .stage_out (stage[k])
    );
  end

  des_output_stage u_output_stage (
    .stage_in   (stage[NUM_ROUNDS]),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
  );

endmodule

`default_nettype wire

/* dv/des_encrypt_properties.sv */
// Bound checks on the DES core valid strobe and ciphertext
`timescale 1ns/10ps
`default_nettype none

module des_encrypt_properties
  import des_pkg::*;
(
  input wire logic   clk,
  input wire logic   arst_n,
  input wire logic   in_valid,
  input wire logic   out_valid,
  input wire block_t ciphertext
);

  localparam int LATENCY = 17;

  logic [4:0] since_rst;  // Saturating count of edges since reset release

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      since_rst <= '0;
    else if (since_rst != 5'd31)
      since_rst <= since_rst + 5'd1;
  end

  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    (since_rst >= 5'd17) |-> (out_valid == $past(in_valid, LATENCY)))
    else $error("out_valid does not follow in_valid by 17 cycles");

  a_low_in_reset: assert property (@(posedge clk)
    (!arst_n && $past(!arst_n)) |-> !out_valid)
    else $error("out_valid high during reset");

  // Pipeline still holds cleared stages
  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
    (since_rst < 5'd17) |-> !out_valid)
    else $error("out_valid high before the pipeline filled");

  a_known_data: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> !$isunknown(ciphertext))
    else $error("ciphertext has unknown bits while out_valid is high");

endmodule

`default_nettype wire

/* dv/tb_des_encrypt.sv */
// Testbench for the pipelined DES core
// File-driven known answers, streaming, reset, complementation and weak key checks
`timescale 1ns/10ps
`default_nettype none

module tb_des_encrypt
  import des_pkg::*;
();

  localparam int   MAX_VEC  = 32;
  localparam int   LATENCY  = 17;
  localparam key_t WEAK_KEY = 64'h0101010101010101;

  typedef struct packed {
    logic   check;  // Low for results that are only captured
    block_t value;
  } expect_t;

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  block_t  message;
  key_t    key;
  logic    out_valid;
  block_t  ciphertext;
  key_t    vec_key [MAX_VEC];
  block_t  vec_pt [MAX_VEC];
  block_t  vec_ct [MAX_VEC];
  expect_t expq [$];
  expect_t mon_exp;
  block_t  last_ct;
  string   cur_test;
  int      num_vec;
  int      errors;
  int      pulses;
  int      sent;
  int      cycles;
  int      max_cycles;
  integer  seed;

  des_encrypt #(.NUM_ROUNDS(16)) DUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .message    (message),
    .key        (key),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
  );

  bind des_encrypt des_encrypt_properties u_props (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .ciphertext (ciphertext)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > max_cycles)
    begin
      $display("Timeout after %0d cycles, %0d blocks still in flight", cycles, expq.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Results leave in input order
  always @(posedge clk)
  begin
    if (out_valid)
    begin
      pulses++;
      if (expq.size() == 0)
      begin
        errors++;
        $display("%s: out_valid rose with no block in flight", cur_test);
      end
      else
      begin
        mon_exp = expq.pop_front();
        last_ct = ciphertext;
        if (mon_exp.check)
          compare_block(cur_test, mon_exp.value, ciphertext);
      end
    end
  end

  task automatic compare_block(input string name, input block_t exp, input block_t act);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_strobe(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %s out_valid expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic load_stimulus();
    int     fd;
    string  line;
    key_t   k;
    block_t p;
    block_t c;
    num_vec = 0;
    fd = $fopen("dv/des_stim.txt", "r");
    if (fd == 0)
      $display("Cannot open dv/des_stim.txt");
    else
    begin
      while (!$feof(fd) && num_vec < MAX_VEC)
      begin
        if ($fgets(line, fd) != 0)
        begin
          if ($sscanf(line, "%h %h %h", k, p, c) == 3)  // Comment lines do not parse
          begin
            vec_key[num_vec] = k;
            vec_pt[num_vec]  = p;
            vec_ct[num_vec]  = c;
            num_vec++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_block(input key_t k, input block_t m, input logic chk, input block_t exp);
    @(posedge clk);
    in_valid <= 1'b1;
    key      <= k;
    message  <= m;
    expq.push_back(expect_t'{check: chk, value: exp});
    sent++;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    while (expq.size() != 0)
      idle(1);
  endtask

  task automatic watch_quiet(input int n);
    repeat (n)
    begin
      @(negedge clk);
      compare_strobe(cur_test, 1'b0, out_valid);
    end
  endtask

  task automatic report_test(input int errs0);
    $display("test %s finished with %0d errors", cur_test, errors - errs0);
  endtask

  task automatic run_tests();
    int     errs0;
    int     sent0;
    int     pulses0;
    block_t pt;

    errs0 = errors;
    cur_test = "reset_at_start";
    watch_quiet(5);
    @(posedge clk);
    arst_n <= 1'b1;
    watch_quiet(LATENCY + 3);  // Nothing sent yet
    report_test(errs0);

    errs0 = errors;
    cur_test = "known_answers";
    for (int i = 0; i < num_vec; i++)
    begin
      send_block(vec_key[i], vec_pt[i], 1'b1, vec_ct[i]);
      drain();
      idle(2);
    end
    report_test(errs0);

    errs0 = errors;
    cur_test = "streaming";
    sent0 = sent;
    pulses0 = pulses;
    for (int i = 0; i < num_vec; i++)
      send_block(vec_key[i], vec_pt[i], 1'b1, vec_ct[i]);
    for (int i = 0; i < num_vec; i++)
    begin
      send_block(vec_key[i], vec_pt[i], 1'b1, vec_ct[i]);
      if ($random(seed) % 2 != 0)
        idle(1);
    end
    drain();
    if (pulses - pulses0 != sent - sent0)
    begin
      errors++;
      $display("[FAIL] %s pulse count expected %0d actual %0d", cur_test, sent - sent0,
               pulses - pulses0);
    end
    report_test(errs0);

    errs0 = errors;
    cur_test = "reset_in_flight";
    for (int i = 0; i < 5; i++)
      send_block(vec_key[i % num_vec], vec_pt[i % num_vec], 1'b1, vec_ct[i % num_vec]);
    @(posedge clk);
    in_valid <= 1'b0;
    arst_n   <= 1'b0;
    @(negedge clk);
    expq.delete();  // Blocks in flight are lost
    watch_quiet(3);
    @(posedge clk);
    arst_n <= 1'b1;
    watch_quiet(LATENCY + 3);
    report_test(errs0);

    errs0 = errors;
    cur_test = "complement";
    for (int i = 0; i < num_vec; i++)
      send_block(~vec_key[i], ~vec_pt[i], 1'b1, ~vec_ct[i]);
    drain();
    report_test(errs0);

    // Encryption under a weak key is its own inverse
    errs0 = errors;
    cur_test = "weak_key";
    for (int n = 0; n < 4; n++)
    begin
      pt = {$random(seed), $random(seed)};
      send_block(WEAK_KEY, pt, 1'b0, '0);
      drain();
      send_block(WEAK_KEY, last_ct, 1'b1, pt);
      drain();
    end
    report_test(errs0);
  endtask

  initial
  begin
    clk = 1'b0;
    arst_n   <= 1'b0;
    in_valid <= 1'b0;
    message  <= '0;
    key      <= '0;
    seed = 32'h0e88_56c3;
    errors = 0;
    pulses = 0;
    sent = 0;
    cycles = 0;
    cur_test = "setup";
    load_stimulus();
    // Known answers take about 20 cycles a vector and the other tests a few more
    max_cycles = num_vec * 24 + LATENCY * 16 + 200;
    if (num_vec == 0)
    begin
      errors++;
      $display("No usable vectors in the stimulus file");
    end
    else
      run_tests();
    $display("Summary %0d vectors, %0d blocks sent, %0d errors", num_vec, sent, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* des_encrypt.f */
hw/des_pkg.sv
hw/des_input_stage.sv
hw/des_round.sv
hw/des_output_stage.sv
hw/des_encrypt.sv
dv/des_encrypt_properties.sv
dv/tb_des_encrypt.sv

/* Makefile */
# Verilator build and run for the pipelined DES core
TOP   = tb_des_encrypt
BUILD = obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module $(TOP) -Mdir $(BUILD) -f des_encrypt.f
	./$(BUILD)/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	  if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" sim.log; then \
	    echo "Simulation reported failure"; exit 1; \
	  fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps \
	  --top-module $(TOP) -f des_encrypt.f

clean:
	rm -rf $(BUILD) sim.log

/* dv/des_stim.txt */
// DES known-answer vectors, one per line
// Columns are key, plaintext and expected ciphertext in hex
133457799BBCDFF1 0123456789ABCDEF 85E813540F0AB405
0E329232EA6D0D73 8787878787878787 0000000000000000
0123456789ABCDEF 4E6F772069732074 3FA40E8A984D4815
0000000000000000 0000000000000000 8CA64DE9C1B123A7
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 7359B2163E4EDC58
3000000000000000 1000000000000001 958E6E627A05557B
1111111111111111 1111111111111111 F40379AB9E0EC533
0123456789ABCDEF 1111111111111111 17668DFC7292532D
1111111111111111 0123456789ABCDEF 8A5AE1F81AB8F2DD
FEDCBA9876543210 0123456789ABCDEF ED39D950FA74BCC4
7CA110454A1A6E57 01A1D6D039776742 690F5B0D9A26939B
